/* acq.f */
logic/acq_stream_pkg.sv
logic/acq_cfg_pkg.sv
logic/acq_align.sv
logic/acq_trg.sv
logic/acq_ctl.sv
logic/acq_top.sv
tb/acq_assertions.sv
tb/acq_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the acquisition testbench with Verilator.
# Exit status is 0 only when the log holds the pass message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module acq_tb \
  -Mdir obj_dir \
  -f acq.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vacq_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '\*\*\* TEST PASSED \*\*\*' "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see $LOG"
  exit 1
fi

/* tb/acq_tb.sv */
//////////////////////////////////////////////////
// acquisition block testbench
// directed tests for triggers, counting, stop,
// back pressure and reset of the top level
//////////////////////////////////////////////////

`timescale 1ns/1ps

module acq_tb
  import acq_stream_pkg::*;
  import acq_cfg_pkg::*;
();

  localparam int unsigned CW = 16;
  localparam int unsigned TW = 32;
  // strobe selectors
  localparam int P_STR = 0;
  localparam int P_STP = 1;
  localparam int P_TRG = 2;
  // test lengths in cycles plus a margin for the limit
  localparam int T_LEN = 60 + 60 + 70 + 60 + 300 + 60;
  localparam int TIMEOUT = T_LEN + 200;

  logic          sti;
  logic          ctl_rst;
  logic          in_valid;
  acq_beat_t     in_beat;
  logic          in_ready;
  logic          out_valid;
  acq_beat_t     out_beat;
  logic          out_ready;
  logic          ctl_str;
  logic          ctl_stp;
  logic          ctl_trg;
  acq_mode_t     cfg_mode;
  acq_trg_cfg_t  cfg_trg;
  logic [CW-1:0] cfg_pre;
  logic [CW-1:0] cfg_pst;
  logic [TW-1:0] cts;
  acq_sts_t      sts;
  logic [CW-1:0] sts_pre;
  logic [CW-1:0] sts_pst;
  logic [TW-1:0] sts_tsp;
  logic          evn_end;

  // source, reference and captured output
  acq_beat_t     src_q[$];
  acq_sample_t   ref_q[$];
  acq_beat_t     out_q[$];
  int            end_cnt;
  logic          rnd_rdy;
  logic [15:0]   lfsr;
  // expected trigger timestamp
  acq_sample_t   tsp_smp;
  logic          hit_acc;
  logic [TW-1:0] tsp_exp;
  string         tn;
  int            err_cnt;
  int            err_at;
  int            test_cnt;
  int            fail_cnt;
  int            cyc;

  acq_top #(
    .CW (CW),
    .TW (TW)
  ) dut (
    .sti       (sti),
    .ctl_rst   (ctl_rst),
    .in_valid  (in_valid),
    .in_beat   (in_beat),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_beat  (out_beat),
    .out_ready (out_ready),
    .ctl_str   (ctl_str),
    .ctl_stp   (ctl_stp),
    .ctl_trg   (ctl_trg),
    .cfg_mode  (cfg_mode),
    .cfg_trg   (cfg_trg),
    .cfg_pre   (cfg_pre),
    .cfg_pst   (cfg_pst),
    .cts       (cts),
    .sts       (sts),
    .sts_pre   (sts_pre),
    .sts_pst   (sts_pst),
    .sts_tsp   (sts_tsp),
    .evn_end   (evn_end)
  );

  //////////////////////////////////////////////////
  // clock, time base, source, sink
  //////////////////////////////////////////////////

  initial begin
    sti = 1'b0;
    forever #4 sti = ~sti;
  end

  initial begin
    cts <= TW'(32'h0000_1000);
    forever begin
      @(posedge sti);
      cts <= cts + TW'(1);
    end
  end

  // next beat once the held one is taken
  initial begin
    in_valid <= 1'b0;
    in_beat  <= ACQ_BEAT_IDLE;
    forever begin
      @(posedge sti);
      if (!in_valid || in_ready) begin
        if (src_q.size() > 0) begin
          in_valid <= 1'b1;
          in_beat  <= src_q.pop_front();
        end else begin
          in_valid <= 1'b0;
        end
      end
    end
  end

  // galois lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one lfsr bit per cycle for random back pressure
  initial begin
    lfsr      = 16'd50;
    out_ready <= 1'b1;
    forever begin
      @(posedge sti);
      if (rnd_rdy) begin
        lfsr = lfsr_next(lfsr);
        out_ready <= lfsr[0];
      end else begin
        out_ready <= 1'b1;
      end
    end
  end

  always @(posedge sti) begin
    if (!ctl_rst) begin
      if (out_valid && out_ready) begin
        out_q.push_back(out_beat);
      end
      if (evn_end) begin
        end_cnt++;
      end
    end
    // trigger lands one cycle after its sample is accepted
    hit_acc <= in_valid && in_ready && (in_beat.smp == tsp_smp);
    if (hit_acc) begin
      tsp_exp <= cts;
    end
  end

  // watchdog
  initial begin
    cyc = 0;
    while (cyc < TIMEOUT) begin
      @(posedge sti);
      cyc++;
    end
    $display("timeout: tests did not finish within %0d cycles", TIMEOUT);
    $display("*** TEST FAILED ***");
    $finish;
  end

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  task automatic cmp_beat(input string what, input acq_beat_t exp, input acq_beat_t act);
    if (exp !== act) begin
      $display("Mismatch %s %s: expected smp=%0d lst=%0b, actual smp=%0d lst=%0b",
               tn, what, exp.smp, exp.lst, act.smp, act.lst);
      err_cnt++;
    end
  endtask

  task automatic cmp_sts(input string what, input acq_sts_t exp, input acq_sts_t act);
    if (exp !== act) begin
      $display("Mismatch %s %s: expected acq=%0b trg=%0b, actual acq=%0b trg=%0b",
               tn, what, exp.acq, exp.trg, act.acq, act.trg);
      err_cnt++;
    end
  endtask

  task automatic cmp_cnt(input string what, input logic [CW-1:0] exp,
                         input logic [CW-1:0] act);
    if (exp !== act) begin
      $display("Mismatch %s %s: expected %0d, actual %0d", tn, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic cmp_tsp(input string what, input logic [TW-1:0] exp,
                         input logic [TW-1:0] act);
    if (exp !== act) begin
      $display("Mismatch %s %s: expected 0x%08h, actual 0x%08h", tn, what, exp, act);
      err_cnt++;
    end
  endtask

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic apply_reset();
    src_q.delete();
    @(posedge sti);
    ctl_rst <= 1'b1;
    repeat (3) @(posedge sti);
    ctl_rst <= 1'b0;
    out_q.delete();
    ref_q.delete();
    end_cnt = 0;
    tsp_smp = ACQ_SMP_MIN;
  endtask

  task automatic setup(input logic con, input logic aut, input int pre, input int pst,
                       input int lvl, input acq_edge_t edg);
    @(posedge sti);
    cfg_mode.con <= con;
    cfg_mode.aut <= aut;
    cfg_pre      <= CW'(pre);
    cfg_pst      <= CW'(pst);
    cfg_trg.lvl  <= acq_sample_t'(lvl);
    cfg_trg.edg  <= edg;
  endtask

  // one-cycle strobe
  task automatic pulse(input int which);
    @(posedge sti);
    ctl_str <= (which == P_STR);
    ctl_stp <= (which == P_STP);
    ctl_trg <= (which == P_TRG);
    @(posedge sti);
    ctl_str <= 1'b0;
    ctl_stp <= 1'b0;
    ctl_trg <= 1'b0;
  endtask

  // queued on the falling edge away from the source
  task automatic push_seq(input int n, input int first, input int step);
    acq_beat_t b;
    int        i;
    @(negedge sti);
    for (i = 0; i < n; i++) begin
      b.smp = acq_sample_t'(first + i * step);
      b.lst = 1'b0;
      src_q.push_back(b);
      ref_q.push_back(b.smp);
    end
  endtask

  task automatic wait_pre(input logic [CW-1:0] n);
    do @(posedge sti); while (sts_pre < n);
  endtask

  task automatic wait_pst(input logic [CW-1:0] n);
    do @(posedge sti); while (sts_pst < n);
  endtask

  task automatic wait_beats(input int n);
    while (out_q.size() < n) @(posedge sti);
    repeat (4) @(posedge sti);
  endtask

  task automatic wait_end();
    while (end_cnt == 0) @(posedge sti);
    repeat (4) @(posedge sti);
  endtask

  // output must be the reference prefix with last only on the final beat
  task automatic check_frame(input int n);
    acq_beat_t exp_b;
    int        i;
    cmp_cnt("beat count", CW'(n), CW'(out_q.size()));
    for (i = 0; i < n && i < out_q.size() && i < ref_q.size(); i++) begin
      exp_b.smp = ref_q[i];
      exp_b.lst = (i == n - 1);
      cmp_beat($sformatf("beat %0d", i), exp_b, out_q[i]);
    end
  endtask

  task automatic begin_test(input string name);
    tn     = name;
    err_at = err_cnt;
    test_cnt++;
    apply_reset();
  endtask

  task automatic end_test();
    if (err_cnt == err_at) begin
      $display("%s: ok", tn);
    end else begin
      fail_cnt++;
      $display("%s: failed with %0d errors", tn, err_cnt - err_at);
    end
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic test_sw_trigger();
    begin_test("sw_trigger");
    setup(1'b0, 1'b0, 4, 6, ACQ_SMP_MAX, rise);
    pulse(P_STR);
    push_seq(4, 100, 1);
    wait_pre(CW'(4));
    pulse(P_TRG);
    push_seq(10, 104, 1);
    // 4 pre beats then 6 post beats
    wait_beats(10);
    check_frame(10);
    cmp_cnt("sts_pre", CW'(4), sts_pre);
    cmp_cnt("sts_pst", CW'(6), sts_pst);
    cmp_cnt("evn_end pulses", CW'(1), CW'(end_cnt));
    cmp_sts("sts", '{acq: 1'b0, trg: 1'b1}, sts);
    end_test();
  endtask

  task automatic test_level_trigger();
    int idx;
    begin_test("level_trigger");
    setup(1'b0, 1'b0, 0, 4, 50, rise);
    pulse(P_STR);
    push_seq(12, 40, 3);
    // first ramp sample at or above the level
    idx = 0;
    while (ref_q[idx] < acq_sample_t'(50)) idx++;
    tsp_smp = ref_q[idx];
    wait_beats(idx + 4);
    check_frame(idx + 4);
    cmp_cnt("sts_pre", CW'(idx), sts_pre);
    cmp_cnt("sts_pst", CW'(4), sts_pst);
    cmp_tsp("timestamp", tsp_exp, sts_tsp);
    end_test();
  endtask

  task automatic test_early_trigger();
    begin_test("early_trigger");
    setup(1'b0, 1'b0, 4, 3, ACQ_SMP_MAX, rise);
    pulse(P_STR);
    push_seq(2, -20, 1);
    wait_pre(CW'(2));
    pulse(P_TRG);
    @(posedge sti);
    cmp_sts("sts after early strobe", '{acq: 1'b1, trg: 1'b0}, sts);
    push_seq(2, -18, 1);
    wait_pre(CW'(4));
    pulse(P_TRG);
    push_seq(5, -16, 1);
    wait_beats(7);
    check_frame(7);
    cmp_cnt("sts_pre", CW'(4), sts_pre);
    cmp_cnt("sts_pst", CW'(3), sts_pst);
    end_test();
  endtask

  task automatic test_stop_auto();
    int n;
    begin_test("stop_auto");
    setup(1'b1, 1'b1, 0, 2, ACQ_SMP_MAX, rise);
    pulse(P_STR);
    @(posedge sti);
    cmp_sts("sts after start", '{acq: 1'b1, trg: 1'b1}, sts);
    push_seq(20, 500, 2);
    wait_pst(CW'(5));
    pulse(P_STP);
    wait_end();
    n = out_q.size();
    // continuous runs past the post count and stop ends it early
    if (n <= 2 || n >= 20) begin
      $display("%s: stop gave %0d beats, outside the expected range", tn, n);
      err_cnt++;
    end
    check_frame(n);
    cmp_cnt("sts_pst", CW'(n), sts_pst);
    cmp_cnt("evn_end pulses", CW'(1), CW'(end_cnt));
    cmp_sts("sts", '{acq: 1'b0, trg: 1'b1}, sts);
    end_test();
  endtask

  task automatic test_back_pressure();
    begin_test("back_pressure");
    setup(1'b0, 1'b1, 0, 60, ACQ_SMP_MAX, rise);
    rnd_rdy <= 1'b1;
    pulse(P_STR);
    push_seq(80, -1000, 37);
    wait_beats(60);
    rnd_rdy <= 1'b0;
    check_frame(60);
    cmp_cnt("sts_pst", CW'(60), sts_pst);
    end_test();
  endtask

  task automatic test_mid_reset();
    begin_test("mid_reset");
    setup(1'b0, 1'b0, 2, 50, ACQ_SMP_MAX, rise);
    pulse(P_STR);
    push_seq(20, 7, 5);
    wait_pre(CW'(2));
    pulse(P_TRG);
    wait_pst(CW'(3));
    apply_reset();
    @(posedge sti);
    cmp_sts("sts", '{acq: 1'b0, trg: 1'b0}, sts);
    cmp_cnt("sts_pre", '0, sts_pre);
    cmp_cnt("sts_pst", '0, sts_pst);
    cmp_tsp("sts_tsp", '0, sts_tsp);
    if (out_valid !== 1'b0) begin
      $display("%s: out_valid is still high after reset", tn);
      err_cnt++;
    end
    end_test();
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    ctl_rst  <= 1'b1;
    ctl_str  <= 1'b0;
    ctl_stp  <= 1'b0;
    ctl_trg  <= 1'b0;
    cfg_mode <= '0;
    cfg_trg  <= '0;
    cfg_pre  <= '0;
    cfg_pst  <= '0;
    rnd_rdy  = 1'b0;
    err_cnt  = 0;
    test_cnt = 0;
    fail_cnt = 0;
    end_cnt  = 0;
    tsp_smp  = ACQ_SMP_MIN;
    repeat (3) @(posedge sti);
    ctl_rst <= 1'b0;
    test_sw_trigger();
    test_level_trigger();
    test_early_trigger();
    test_stop_auto();
    test_back_pressure();
    test_mid_reset();
    $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule : acq_tb

/* tb/acq_assertions.sv */
//////////////////////////////////////////////////
// acquisition block assertions
// output stall stability, end pulse width and
// trigger only while acquiring
//////////////////////////////////////////////////

`timescale 1ns/1ps

module acq_assertions
  import acq_stream_pkg::*;
  import acq_cfg_pkg::*;
(
  input logic      sti,
  input logic      ctl_rst,
  input logic      out_valid,
  input acq_beat_t out_beat,
  input logic      out_ready,
  input acq_sts_t  sts,
  input logic      evn_end
);

  // stalled beat holds until taken
  a_out_stable : assert property (@(posedge sti) disable iff (ctl_rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)))
    else $error("output beat changed or dropped while stalled");

  // end event is a single cycle
  a_end_pulse : assert property (@(posedge sti) disable iff (ctl_rst)
    evn_end |=> !evn_end)
    else $error("evn_end held longer than one cycle");

  a_trg_in_acq : assert property (@(posedge sti) disable iff (ctl_rst)
    $rose(sts.trg) |-> sts.acq)
    else $error("sts.trg rose while not acquiring");

endmodule : acq_assertions

bind acq_top acq_assertions u_assertions (
  .sti       (sti),
  .ctl_rst   (ctl_rst),
  .out_valid (out_valid),
  .out_beat  (out_beat),
  .out_ready (out_ready),
  .sts       (sts),
  .evn_end   (evn_end)
);

/* logic/acq_top.sv */
//////////////////////////////////////////////////
// acquisition block top level
// alignment slice and level detector side by side,
// followed by the acquisition controller
//////////////////////////////////////////////////

`timescale 1ns/1ps

module acq_top
  import acq_stream_pkg::*;
  import acq_cfg_pkg::*;
#(
  int unsigned CW = 16,  // counter width
  int unsigned TW = 32   // timestamp width
)(
  // clock and reset
  input  logic          sti,
  input  logic          ctl_rst,
  // input stream
  input  logic          in_valid,
  input  acq_beat_t     in_beat,
  output logic          in_ready,
  // output stream
  output logic          out_valid,
  output acq_beat_t     out_beat,
  input  logic          out_ready,
  // control strobes
  input  logic          ctl_str,
  input  logic          ctl_stp,
  input  logic          ctl_trg,
  // configuration
  input  acq_mode_t     cfg_mode,
  input  acq_trg_cfg_t  cfg_trg,
  input  logic [CW-1:0] cfg_pre,
  input  logic [CW-1:0] cfg_pst,
  // free running time
  input  logic [TW-1:0] cts,
  // status
  output acq_sts_t      sts,
  output logic [CW-1:0] sts_pre,
  output logic [CW-1:0] sts_pst,
  output logic [TW-1:0] sts_tsp,
  output logic          evn_end
);

  //////////////////////////////////////////////////
  // internal stream
  //////////////////////////////////////////////////

  logic      aln_valid;
  acq_beat_t aln_beat;
  logic      aln_ready;
  // hit for the beat in the slice
  logic      trg_hit;

  //////////////////////////////////////////////////
  // blocks
  //////////////////////////////////////////////////

  // delay by one beat to match the detector
  acq_align u_align (
    .sti       (sti),
    .ctl_rst   (ctl_rst),
    .in_valid  (in_valid),
    .in_beat   (in_beat),
    .in_ready  (in_ready),
    .aln_valid (aln_valid),
    .aln_beat  (aln_beat),
    .aln_ready (aln_ready)
  );

  // watches the same accepted beats
  acq_trg u_trg (
    .sti      (sti),
    .ctl_rst  (ctl_rst),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_beat  (in_beat),
    .cfg_trg  (cfg_trg),
    .trg_hit  (trg_hit)
  );

  acq_ctl #(
    .CW (CW),
    .TW (TW)
  ) u_ctl (
    .sti       (sti),
    .ctl_rst   (ctl_rst),
    .aln_valid (aln_valid),
    .aln_beat  (aln_beat),
    .aln_ready (aln_ready),
    .trg_hit   (trg_hit),
    .out_valid (out_valid),
    .out_beat  (out_beat),
    .out_ready (out_ready),
    .ctl_str   (ctl_str),
    .ctl_stp   (ctl_stp),
    .ctl_trg   (ctl_trg),
    .cfg_mode  (cfg_mode),
    .cfg_pre   (cfg_pre),
    .cfg_pst   (cfg_pst),
    .cts       (cts),
    .sts       (sts),
    .sts_pre   (sts_pre),
    .sts_pst   (sts_pst),
    .sts_tsp   (sts_tsp),
    .evn_end   (evn_end)
  );

endmodule : acq_top

/* logic/acq_ctl.sv */
//////////////////////////////////////////////////
// acquisition controller
// start, stop and trigger handling, pre and post
// counters, trigger timestamp and gated output
//////////////////////////////////////////////////

`timescale 1ns/1ps

module acq_ctl
  import acq_stream_pkg::*;
  import acq_cfg_pkg::*;
#(
  int unsigned CW = 16,  // counter width
  int unsigned TW = 32   // timestamp width
)(
  // clock and reset
  input  logic          sti,
  input  logic          ctl_rst,
  // aligned stream and its trigger hit
  input  logic          aln_valid,
  input  acq_beat_t     aln_beat,
  output logic          aln_ready,
  input  logic          trg_hit,
  // output stream
  output logic          out_valid,
  output acq_beat_t     out_beat,
  input  logic          out_ready,
  // control strobes
  input  logic          ctl_str,
  input  logic          ctl_stp,
  input  logic          ctl_trg,
  // configuration
  input  acq_mode_t     cfg_mode,
  input  logic [CW-1:0] cfg_pre,
  input  logic [CW-1:0] cfg_pst,
  // current time
  input  logic [TW-1:0] cts,
  // status
  output acq_sts_t      sts,
  output logic [CW-1:0] sts_pre,
  output logic [CW-1:0] sts_pst,
  output logic [TW-1:0] sts_tsp,
  output logic          evn_end
);

  //////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////

  logic          aln_trn;  // aligned beat leaves the slice
  logic          ena_pre;  // pre count satisfied
  logic          trg;      // trigger taken this cycle
  logic [CW-1:0] nxt_pre;
  logic [CW-1:0] nxt_pst;
  logic          end_pst;  // post count reached
  logic          end_lst;  // input frame ended
  logic          sts_end;  // acquisition ends this cycle

  // output register frees up when drained or empty
  assign aln_ready = out_ready | ~out_valid;
  assign aln_trn   = aln_valid & aln_ready;

  assign nxt_pre = sts_pre + CW'(1);
  assign nxt_pst = sts_pst + CW'(1);

  //////////////////////////////////////////////////
  // trigger and end conditions
  //////////////////////////////////////////////////

  // detector hit only counts with its own beat
  // strobe is taken whenever it arrives
  assign trg = sts.acq & ena_pre & ~sts.trg & (ctl_trg | (trg_hit & aln_trn));

  // the beat that fills the post count is the last one
  assign end_pst = aln_trn & (sts.trg | trg) & ~cfg_mode.con & (nxt_pst == cfg_pst);
  assign end_lst = aln_trn & aln_beat.lst;

  // first of stop, post count end, or last input beat
  assign sts_end = sts.acq & (ctl_stp | end_pst | end_lst);

  //////////////////////////////////////////////////
  // status and counters
  //////////////////////////////////////////////////

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      sts     <= '0;
      ena_pre <= 1'b0;
      sts_pre <= '0;
      sts_pst <= '0;
      sts_tsp <= '0;
    end else if (~sts.acq) begin
      // idle, wait for start
      if (ctl_str) begin
        sts.acq <= 1'b1;
        sts.trg <= cfg_mode.aut;
        ena_pre <= (cfg_pre == '0);
        sts_pre <= '0;
        sts_pst <= '0;
        // automatic mode triggers now
        sts_tsp <= cfg_mode.aut ? cts : '0;
      end
    end else begin
      if (trg) begin
        sts.trg <= 1'b1;
        sts_tsp <= cts;
      end
      // only forwarded beats are counted
      if (aln_trn) begin
        if (sts.trg | trg) begin
          sts_pst <= nxt_pst;
        end else begin
          sts_pre <= nxt_pre;
          if (nxt_pre == cfg_pre) begin
            ena_pre <= 1'b1;
          end
        end
      end
      // trg stays set after the end for software
      if (sts_end) begin
        sts.acq <= 1'b0;
      end
    end
  end

  // end event, one cycle after the condition
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      evn_end <= 1'b0;
    end else begin
      evn_end <= sts_end;
    end
  end

  //////////////////////////////////////////////////
  // output stream
  //////////////////////////////////////////////////

  // beats are dropped while idle
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      out_valid <= 1'b0;
    end else if (aln_ready) begin
      out_valid <= sts.acq & aln_valid;
    end
  end

  // last is forced on the closing beat
  always_ff @(posedge sti) begin
    if (sts.acq & aln_trn) begin
      out_beat.smp <= aln_beat.smp;
      out_beat.lst <= aln_beat.lst | sts_end;
    end
  end

endmodule : acq_ctl

/* logic/acq_trg.sv */
//////////////////////////////////////////////////
// acquisition level trigger
// flags a crossing of the configured level between
// two consecutive accepted samples
//////////////////////////////////////////////////

`timescale 1ns/1ps

module acq_trg
  import acq_stream_pkg::*;
  import acq_cfg_pkg::*;
(
  // clock and reset
  input  logic         sti,
  input  logic         ctl_rst,
  // input stream, observed only
  input  logic         in_valid,
  input  logic         in_ready,
  input  acq_beat_t    in_beat,
  // level and direction
  input  acq_trg_cfg_t cfg_trg,
  // hit for the beat held in the alignment slice
  output logic         trg_hit
);

  //////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////

  logic        in_trn;    // accepted input beat
  logic        prv_vld;   // previous sample present
  acq_sample_t prv_smp;   // previous accepted sample
  acq_sample_t cur_smp;   // sample being accepted
  acq_sample_t lvl;       // trigger level
  logic        crs_rise;
  logic        crs_fall;
  logic        crs;

  assign in_trn  = in_valid & in_ready;
  assign cur_smp = in_beat.smp;
  assign lvl     = cfg_trg.lvl;

  //////////////////////////////////////////////////
  // crossing compare
  //////////////////////////////////////////////////

  // signed compares, both operands are sample typed
  assign crs_rise = (prv_smp <  lvl) & (cur_smp >= lvl);
  assign crs_fall = (prv_smp >= lvl) & (cur_smp <  lvl);

  // no history yet means no crossing
  assign crs = prv_vld & ((cfg_trg.edg == rise) ? crs_rise : crs_fall);

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  // hit moves in step with the alignment slice
  // so it always belongs to the held beat
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      prv_vld <= 1'b0;
      trg_hit <= 1'b0;
    end else if (in_trn) begin
      prv_vld <= 1'b1;
      trg_hit <= crs;
    end
  end

  // sample history
  always_ff @(posedge sti) begin
    if (in_trn) begin
      prv_smp <= cur_smp;
    end
  end

endmodule : acq_trg

/* logic/acq_align.sv */
//////////////////////////////////////////////////
// acquisition alignment slice
// holds one input beat for a cycle so the beat
// lines up with its registered trigger decision
//////////////////////////////////////////////////

`timescale 1ns/1ps

module acq_align
  import acq_stream_pkg::*;
(
  // clock and reset
  input  logic      sti,
  input  logic      ctl_rst,
  // input stream
  input  logic      in_valid,
  input  acq_beat_t in_beat,
  output logic      in_ready,
  // aligned stream towards the controller
  output logic      aln_valid,
  output acq_beat_t aln_beat,
  input  logic      aln_ready
);

  //////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////

  // slice takes a beat when empty or when the
  // held beat leaves in the same cycle
  assign in_ready = aln_ready | ~aln_valid;

  // full flag
  // a stalled downstream keeps the held beat
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      aln_valid <= 1'b0;
    end else if (in_ready) begin
      aln_valid <= in_valid;
    end
  end

  //////////////////////////////////////////////////
  // payload
  //////////////////////////////////////////////////

  // beat register, loads on every accepted beat
  always_ff @(posedge sti) begin
    if (in_valid & in_ready) begin
      aln_beat <= in_beat;
    end
  end

endmodule : acq_align

/* logic/acq_cfg_pkg.sv */
//////////////////////////////////////////////////
// acquisition configuration and status types
// mode flags, trigger setup and the status word
// seen by software
//////////////////////////////////////////////////

package acq_cfg_pkg;

  //////////////////////////////////////////////////
  // mode
  //////////////////////////////////////////////////

  // acquisition mode flags
  typedef struct packed {
    logic con;  // continuous, post count does not stop
    logic aut;  // automatic, triggered right at start
  } acq_mode_t;

  //////////////////////////////////////////////////
  // trigger
  //////////////////////////////////////////////////

  // crossing direction of the level detector
  typedef enum logic {
    rise = 1'b0,  // below level, then at or above
    fall = 1'b1   // at or above level, then below
  } acq_edge_t;

  // level detector setup
  // level has the same format as the samples
  typedef struct packed {
    acq_stream_pkg::acq_sample_t lvl;  // crossing level
    acq_edge_t                   edg;  // crossing direction
  } acq_trg_cfg_t;

  //////////////////////////////////////////////////
  // status
  //////////////////////////////////////////////////

  // counts have a variable width and travel beside this
  typedef struct packed {
    logic acq;  // acquisition running
    logic trg;  // trigger seen
  } acq_sts_t;

endpackage : acq_cfg_pkg

/* logic/acq_stream_pkg.sv */
//////////////////////////////////////////////////
// acquisition stream types
// sample word and the beat that travels on every
// valid/ready hop of the data path
//////////////////////////////////////////////////

package acq_stream_pkg;

  //////////////////////////////////////////////////
  // sample
  //////////////////////////////////////////////////

  // sample width in bits
  localparam int unsigned SW = 16;

  // one signed converter sample, two's complement
  typedef logic signed [SW-1:0] acq_sample_t;

  //////////////////////////////////////////////////
  // stream beat
  //////////////////////////////////////////////////

  // payload of one stream transfer
  // lst marks the final beat of an acquisition
  typedef struct packed {
    acq_sample_t smp;  // sample value
    logic        lst;  // last beat of the frame
  } acq_beat_t;

  // beat width, handy for wide buses and checks
  localparam int unsigned BW = $bits(acq_beat_t);

  // idle beat, zero sample and no last flag
  localparam acq_beat_t ACQ_BEAT_IDLE = '{smp: '0, lst: 1'b0};

  // smallest and largest sample values
  localparam acq_sample_t ACQ_SMP_MIN = {1'b1, {(SW-1){1'b0}}};
  localparam acq_sample_t ACQ_SMP_MAX = {1'b0, {(SW-1){1'b1}}};

endpackage : acq_stream_pkg
